// ==== Makefile ====
# Verilator build and run of the counter display testbench

VERILATOR := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := counter_display_tb
FILE_LIST := verilog.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_TEXT := Everything OK
FAIL_TEXT := Something failed

SOURCES := $(wildcard design/*.sv verification/*.sv include/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_TEXT)" $(LOG); then echo "simulation did not finish"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== design/bin_to_bcd.sv ====
//**************************************************************************
// binary to BCD converter, sequential double dabble, one bit per clock
//**************************************************************************

`timescale 1ns/1ns

module bin_to_bcd
	import display_pkg::*;
(
	input  logic                    clock,
	input  logic                    arst_n,
	input  logic                    start,     // sample binary_in, restarts a running conversion
	input  logic [binary_width-1:0] binary_in,
	output bcd_word_t               bcd_value, // result, valid from done onward
	output logic                    done       // one clock, new result
);

	bcd_word_t                  shift_bcd; // BCD half of the shifter
	bcd_word_t                  adjusted;  // digits after add-three
	bcd_word_t                  next_bcd;  // digits after this step's shift
	logic [binary_width-1:0]    shift_bin; // binary bits still to go, msb first
	logic [bit_count_width-1:0] bit_count; // shifts left in this run
	logic                       busy;
	logic                       last_step;

	// add three to every digit of five or more, so the shift carries correctly
	always_comb begin
		adjusted = shift_bcd;
		for (int i = 0; i < digit_count; i++) begin
			if (shift_bcd.digit[i] >= 4'd5) begin
				adjusted.digit[i] = shift_bcd.digit[i] + 4'd3;
			end
		end
	end

	// shift left by one, next binary bit enters at the bottom
	assign next_bcd.flat = {adjusted.flat[bcd_width-2:0], shift_bin[binary_width-1]};

	assign last_step = busy && !start && (bit_count == bit_count_width'(1));

	// control: bit counter and done strobe
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			busy      <= 1'b0;
			bit_count <= '0;
			done      <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				busy      <= 1'b1; // a start always wins, even mid run
				bit_count <= bit_count_width'(binary_width);
			end else if (busy) begin
				bit_count <= bit_count - 1'b1;
				if (last_step) begin
					busy <= 1'b0;
					done <= 1'b1; // lines up with bcd_value below
				end
			end
		end
	end

	// datapath
	always_ff @(posedge clock) begin
		if (start) begin
			shift_bcd.flat <= '0;
			shift_bin      <= binary_in;
		end else if (busy) begin
			shift_bcd <= next_bcd;
			shift_bin <= shift_bin << 1;
		end
		if (last_step) begin
			bcd_value <= next_bcd; // only touched once the run is complete
		end
	end

	// done lands exactly binary_width plus one clocks after its start
	a_done_latency: assert property (
		@(posedge clock) disable iff (!arst_n)
		done |-> $past(start, binary_width + 1)
	) else $error("conversion latency wrong");

	// a finished word holds decimal digits only
	for (genvar d = 0; d < digit_count; d++) begin : g_digit_check
		a_decimal: assert property (
			@(posedge clock) disable iff (!arst_n)
			done |-> (bcd_value.digit[d] <= 4'd9)
		) else $error("digit %0d of result is not decimal", d);
	end

endmodule

// ==== design/counter_display_top.sv ====
//**************************************************************************
// counter display top: event counter feeding a BCD converter that feeds
// a multiplexed seven digit common anode display
//**************************************************************************

`timescale 1ns/1ns

module counter_display_top
	import display_pkg::*;
(
	input  logic                     clock,
	input  logic                     arst_n,
	input  logic                     run,        // count ticks while high
	input  logic                     load,       // preset the count
	input  logic [binary_width-1:0]  load_value,
	output logic [segment_count-1:0] cathode,    // active low, dp in bit zero
	output logic [digit_count-1:0]   anode,      // active high, one-hot
	output logic                     frame_sync  // start of each scan frame
);

	logic [binary_width-1:0] count_value;
	logic                    count_changed; // starts a conversion
	bcd_word_t               bcd_value;
	logic                    bcd_done;      // result ready for the scanner

	// count source
	tick_counter u_tick_counter (
		.clock         (clock),
		.arst_n        (arst_n),
		.run           (run),
		.load          (load),
		.load_value    (load_value),
		.count_value   (count_value),
		.count_changed (count_changed)
	);

	// every count change restarts the conversion
	bin_to_bcd u_bin_to_bcd (
		.clock     (clock),
		.arst_n    (arst_n),
		.start     (count_changed),
		.binary_in (count_value),
		.bcd_value (bcd_value),
		.done      (bcd_done)
	);

	// display side
	digit_scanner u_digit_scanner (
		.clock      (clock),
		.arst_n     (arst_n),
		.bcd_value  (bcd_value),
		.bcd_done   (bcd_done),
		.cathode    (cathode),
		.anode      (anode),
		.frame_sync (frame_sync)
	);

endmodule

// ==== design/digit_scanner.sv ====
//**************************************************************************
// digit scanner: one digit lit at a time, leading zero blanking,
// fixed decimal point and a frame sync at the start of digit zero
//**************************************************************************

`timescale 1ns/1ns

module digit_scanner
	import display_pkg::*;
(
	input  logic                     clock,
	input  logic                     arst_n,
	input  bcd_word_t                bcd_value,
	input  logic                     bcd_done,   // copy bcd_value on this pulse
	output logic [segment_count-1:0] cathode,    // g..a then dp in bit zero, active low
	output logic [digit_count-1:0]   anode,      // active high, one-hot
	output logic                     frame_sync  // first clock of digit zero
);

	`include "seven_segment_font.svh"

	bcd_word_t                    display_word; // word being shown
	logic [dwell_width-1:0]       dwell;        // clocks into the current digit
	logic [digit_index_width-1:0] digit_index;  // digit currently lit
	logic [digit_index_width-1:0] next_index;
	logic [digit_count-1:0]       blank_digit;  // leading zero flags
	logic                         dwell_wrap;
	logic                         next_dp;

	assign dwell_wrap = (dwell == dwell_width'(scan_dwell - 1));
	assign next_index = (digit_index == digit_index_width'(digit_count - 1))
		? '0 : digit_index + 1'b1;
	assign next_dp = (next_index == digit_index_width'(dp_digit));

	// a digit is blank when it and everything above it are zero
	always_comb begin
		logic higher_zero;
		higher_zero = 1'b1;
		for (int i = digit_count - 1; i >= 0; i--) begin
			higher_zero    = higher_zero && (display_word.digit[i] == 4'd0);
			blank_digit[i] = higher_zero && (i != 0); // units digit always shows
		end
	end

	// display register, zero after reset so a single 0 shows
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			display_word.flat <= '0;
		end else if (bcd_done) begin
			display_word <= bcd_value;
		end
	end

	// scan: dwell counter, anode rotation and the digit's cathode pattern
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			dwell       <= '0;
			digit_index <= '0;
			anode       <= digit_count'(1); // digit zero lit
			frame_sync  <= 1'b0;
			cathode     <= {segment_pattern(4'd0, 1'b0), 1'b1}; // "0", dp off
		end else begin
			frame_sync <= 1'b0;
			if (dwell_wrap) begin
				dwell       <= '0;
				digit_index <= next_index;
				anode       <= {anode[digit_count-2:0], anode[digit_count-1]}; // move up one digit
				// new word takes effect here, at the digit boundary
				cathode     <= {segment_pattern(display_word.digit[next_index],
					blank_digit[next_index]), ~next_dp};
				frame_sync  <= (next_index == '0); // back to the units digit
			end else begin
				dwell <= dwell + 1'b1;
			end
		end
	end

	// never two digits at once, never dark
	a_anode_onehot: assert property (
		@(posedge clock) disable iff (!arst_n)
		$onehot(anode)
	) else $error("anode not one-hot");

	// anode and digit index move together
	a_anode_index: assert property (
		@(posedge clock) disable iff (!arst_n)
		anode[digit_index]
	) else $error("anode out of step with digit index");

endmodule

// ==== design/display_pkg.sv ====
//**************************************************************************
// display package: widths, timing constants and the shared BCD word type
// for the event counter, the BCD converter and the digit scanner
//**************************************************************************

package display_pkg;

	// count and display sizes
	localparam int binary_width  = 20; // count width, max 1048575
	localparam int digit_count   = 7;  // seven digits hold 1048575
	localparam int nybble_width  = 4;  // one BCD digit
	localparam int segment_count = 8;  // g..a plus decimal point
	localparam int bcd_width     = nybble_width * digit_count;

	// timing
	localparam int tick_period = 12; // clocks per count tick, keep a multiple of three
	localparam int scan_dwell  = 8;  // clocks each digit stays lit
	localparam int dp_digit    = 3;  // thousands mark

	// prescaler runs one third of the tick period, the token ring does the rest
	localparam int prescale_period = tick_period / 3;
	localparam int prescale_width  = $clog2(prescale_period);

	// counter widths derived from the above
	localparam int bit_count_width   = $clog2(binary_width + 1);
	localparam int dwell_width       = $clog2(scan_dwell);
	localparam int digit_index_width = $clog2(digit_count);

	// one BCD word, seen flat by the shifter and per digit by the scanner
	typedef union packed {
		logic [bcd_width-1:0]                      flat;
		logic [digit_count-1:0][nybble_width-1:0] digit;
	} bcd_word_t;

endpackage

// ==== design/tick_counter.sv ====
//**************************************************************************
// event counter: prescaler plus three stage token ring make the count tick,
// binary count is loadable and flags every change
//**************************************************************************

`timescale 1ns/1ns

module tick_counter
	import display_pkg::*;
(
	input  logic                    clock,
	input  logic                    arst_n,
	input  logic                    run,        // count on ticks while high
	input  logic                    load,       // preset strobe, wins over counting
	input  logic [binary_width-1:0] load_value,
	output logic [binary_width-1:0] count_value,
	output logic                    count_changed // one clock, with the new value
);

	logic [prescale_width-1:0] prescale; // clocks within one token stage
	logic [2:0]                token;    // rotating one-hot stage
	logic                      prescale_wrap;
	logic                      tick;

	assign prescale_wrap = (prescale == prescale_width'(prescale_period - 1));
	assign tick = prescale_wrap && token[0]; // once per full ring turn

	// prescaler and token ring, both restart on load
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			prescale <= '0;
			token    <= 3'b001;
		end else if (load) begin
			prescale <= '0;
			token    <= 3'b001;
		end else if (prescale_wrap) begin
			prescale <= '0;
			token    <= {token[1:0], token[2]}; // barrel shift one stage
		end else begin
			prescale <= prescale + 1'b1;
		end
	end

	// the count itself
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			count_value   <= '0;
			count_changed <= 1'b0;
		end else begin
			count_changed <= 1'b0; // default, pulse only
			if (load) begin
				count_value   <= load_value;
				count_changed <= 1'b1;
			end else if (tick && run) begin
				count_value   <= count_value + 1'b1; // wraps from all ones to zero
				count_changed <= 1'b1;
			end
		end
	end

	// a lost or doubled token would skew the tick period
	a_token_onehot: assert property (
		@(posedge clock) disable iff (!arst_n)
		$onehot(token)
	) else $error("token ring lost its single token");

endmodule

// ==== include/seven_segment_font.svh ====
//**************************************************************************
// seven segment font, active low patterns for segments g down to a
//**************************************************************************

// bit 6 is segment g, bit 0 is segment a, a zero lights the segment
function automatic logic [6:0] segment_pattern(
	input logic [3:0] nybble,
	input logic       blank
);
	logic [6:0] lit; // active high while building
	case (nybble)
		4'd0:    lit = 7'b0111111;
		4'd1:    lit = 7'b0000110;
		4'd2:    lit = 7'b1011011;
		4'd3:    lit = 7'b1001111;
		4'd4:    lit = 7'b1100110;
		4'd5:    lit = 7'b1101101;
		4'd6:    lit = 7'b1111101;
		4'd7:    lit = 7'b0000111;
		4'd8:    lit = 7'b1111111;
		4'd9:    lit = 7'b1101111;
		default: lit = 7'b0000000; // not a decimal digit, show nothing
	endcase
	if (blank) begin
		lit = 7'b0000000;
	end
	return ~lit; // common anode, cathodes pull low
endfunction

// ==== verification/clock_gen.sv ====
//**************************************************************************
// testbench clock and reset, 4 ns period, reset low for four cycles
//**************************************************************************

`timescale 1ns/1ns

module clock_gen (
	output logic clock,
	output logic arst_n
);

	localparam int half_period  = 2; // ns
	localparam int reset_cycles = 4;

	initial begin
		clock = 1'b0;
		forever #half_period clock = ~clock;
	end

	// release on a falling edge, away from the DUT's sampling edge
	initial begin
		arst_n = 1'b0;
		repeat (reset_cycles) @(posedge clock);
		@(negedge clock);
		arst_n = 1'b1;
	end

endmodule

// ==== verification/counter_display_tb.sv ====
//**************************************************************************
// counter display testbench: drives a table of loads and run periods and
// rebuilds the shown number from the scanned cathode and anode lines
//**************************************************************************

`timescale 1ns/1ns

module counter_display_tb
	import display_pkg::*;
;

	`include "seven_segment_font.svh"

	localparam int clock_period  = 4;                        // ns
	localparam int frame_clocks  = digit_count * scan_dwell; // one full scan
	localparam int text_width    = 8 * digit_count;          // one char per digit
	localparam int table_size    = 13;
	localparam int random_count  = 6;
	localparam int static_frames = 3; // syncs to wait, the last frame is then clean

	typedef logic [text_width-1:0] text_t;

	typedef struct packed {
		logic                    do_load; // preset before this entry
		logic [binary_width-1:0] value;
		logic                    run;     // count during the entry
		logic [7:0]              frames;  // syncs to wait, or frames to run
		text_t                   text;    // expected digits, unused while running
	} entry_t;

	entry_t table_entries [table_size] = '{
		'{1'b1, 20'd0,       1'b0, 8'd3, text_t'("0")},
		'{1'b1, 20'd7,       1'b0, 8'd3, text_t'("7")},
		'{1'b1, 20'd10,      1'b0, 8'd3, text_t'("10")},
		'{1'b1, 20'd305,     1'b0, 8'd3, text_t'("305")},
		'{1'b1, 20'd1234,    1'b0, 8'd3, text_t'("1234")},
		'{1'b1, 20'd90005,   1'b0, 8'd3, text_t'("90005")},
		'{1'b1, 20'd1000000, 1'b0, 8'd3, text_t'("1000000")},
		'{1'b1, 20'd1048575, 1'b0, 8'd3, text_t'("1048575")},
		'{1'b1, 20'd500,     1'b1, 8'd4, text_t'(0)},  // count from a load
		'{1'b0, 20'd0,       1'b1, 8'd3, text_t'(0)},  // carry on from there
		'{1'b1, 20'd1048575, 1'b1, 8'd2, text_t'(0)},  // wraps through zero
		'{1'b0, 20'd0,       1'b1, 8'd2, text_t'(0)},
		'{1'b1, 20'd9995,    1'b1, 8'd3, text_t'(0)}   // ripple into a new digit
	};

	logic                     clock;
	logic                     arst_n;
	logic                     run;
	logic                     load;
	logic [binary_width-1:0]  load_value;
	logic [segment_count-1:0] cathode;
	logic [digit_count-1:0]   anode;
	logic                     frame_sync;

	int   errors = 0;
	int   checks = 0;
	int   sync_count = 0;   // frame_syncs seen so far
	int   since_sync = 0;   // clocks since the last frame_sync
	int   last_value = 0;   // last value read back, base for a continued run
	logic sync_seen = 1'b0;
	logic [segment_count-1:0] recording  [digit_count]; // frame being scanned
	logic [segment_count-1:0] last_frame [digit_count]; // last complete frame

	clock_gen u_clock_gen (
		.clock  (clock),
		.arst_n (arst_n)
	);

	counter_display_top u_counter_display_top (
		.clock      (clock),
		.arst_n     (arst_n),
		.run        (run),
		.load       (load),
		.load_value (load_value),
		.cathode    (cathode),
		.anode      (anode),
		.frame_sync (frame_sync)
	);

	task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
		input string what);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Error at %0t ns: %s, got %0h, expected %0h", $time, what, actual, expected);
		end
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] state);
		logic [31:0] x;
		x = state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// ascii digits of v, most significant first, no leading zeros
	function automatic text_t decimal_text(input int v);
		text_t text;
		int    rest;
		text = '0;
		rest = v;
		for (int pos = 0; pos < digit_count; pos++) begin
			if (pos == 0 || rest > 0) begin
				text[pos*8 +: 8] = 8'(48 + rest % 10);
			end
			rest = rest / 10;
		end
		return text;
	endfunction

	// display monitor, sampled on the falling edge where outputs are settled
	always @(negedge clock) begin
		if (arst_n) begin
			check_value(64'($onehot(anode)), 64'd1, "anode one-hot");
			if (frame_sync) begin
				check_value(64'(anode), 64'd1, "frame_sync away from digit zero");
				if (sync_seen) begin
					check_value(64'(since_sync), 64'(frame_clocks), "frame length in clocks");
					last_frame = recording; // a whole frame lies behind this sync
				end
				sync_seen  = 1'b1;
				since_sync = 0;
				sync_count++;
			end
			since_sync++;
			for (int i = 0; i < digit_count; i++) begin
				if (anode[i]) begin
					recording[i] = cathode;
				end
			end
		end
	end

	task automatic wait_frames(input int count);
		int target;
		target = sync_count + count;
		wait (sync_count >= target);
	endtask

	// turn the last frame back into a number; blank reads as a leading zero
	task automatic read_frame(output int value, output text_t text);
		int digit;
		value = 0;
		text  = '0;
		for (int i = digit_count - 1; i >= 0; i--) begin
			digit = -1;
			for (int n = 0; n < 10; n++) begin
				if (last_frame[i][segment_count-1:1] == segment_pattern(4'(n), 1'b0)) begin
					digit = n;
				end
			end
			if (digit >= 0) begin
				value = value * 10 + digit;
				text  = {text[text_width-9:0], 8'(48 + digit)};
			end else begin
				value = value * 10;
				if (last_frame[i][segment_count-1:1] != segment_pattern(4'd0, 1'b1)) begin
					text = {text[text_width-9:0], 8'h3f}; // unreadable, shown as '?'
				end
			end
		end
	endtask

	// every digit, its blanking and the decimal point against the expected value
	task automatic check_frame(input int expected);
		int                       rest;
		int                       digit;
		logic                     blank;
		logic [segment_count-1:0] pattern;
		rest = expected;
		for (int i = 0; i < digit_count; i++) begin
			digit   = rest % 10;
			blank   = (i != 0) && (rest == 0); // nothing left above this digit
			pattern = {segment_pattern(4'(digit), blank), logic'(i != dp_digit)};
			check_value(64'(last_frame[i]), 64'(pattern),
				$sformatf("digit %0d while showing %0d", i, expected));
			rest = rest / 10;
		end
	endtask

	task automatic load_count(input logic [binary_width-1:0] value, input logic run_level);
		@(negedge clock);
		load       = 1'b1;
		load_value = value;
		run        = run_level;
		@(negedge clock);
		load = 1'b0;
	endtask

	task automatic static_entry(input logic [binary_width-1:0] value, input text_t text,
		input int frames);
		int    shown;
		text_t shown_text;
		load_count(value, 1'b0);
		wait_frames(frames);
		read_frame(shown, shown_text);
		check_value(64'(shown_text), 64'(text), $sformatf("text shown for %0d", value));
		check_frame(int'(value));
		last_value = int'(value);
	endtask

	task automatic run_entry(input entry_t entry);
		int    modulus;
		int    run_clocks;
		int    start;
		int    expected;
		int    shown;
		int    diff;
		text_t shown_text;
		modulus    = 1 << binary_width;
		run_clocks = int'(entry.frames) * frame_clocks;
		if (entry.do_load) begin
			start = int'(entry.value);
			load_count(entry.value, 1'b1);
		end else begin
			start = last_value;
			@(negedge clock);
			run = 1'b1;
		end
		repeat (run_clocks) @(negedge clock);
		run = 1'b0;
		wait_frames(static_frames); // let the count settle on the display
		read_frame(shown, shown_text);
		expected = (start + run_clocks / tick_period) % modulus;
		diff     = (shown - expected + modulus) % modulus; // one tick either way is fine
		check_value(64'(diff == 0 || diff == 1 || diff == modulus - 1), 64'd1,
			$sformatf("count %0d after %0d clocks from %0d, about %0d expected",
			shown, run_clocks, start, expected));
		check_frame(shown);
		last_value = shown;
	endtask

	initial begin : stimulus
		int                      shown;
		text_t                   shown_text;
		logic [31:0]             seed;
		logic [binary_width-1:0] random_value;
		run        = 1'b0;
		load       = 1'b0;
		load_value = '0;
		seed       = 32'h1c20;
		@(posedge arst_n);
		wait_frames(2); // first frame after reset is complete
		read_frame(shown, shown_text);
		check_value(64'(shown_text), 64'(text_t'("0")), "text after reset");
		check_frame(0);
		foreach (table_entries[e]) begin
			if (table_entries[e].run) begin
				run_entry(table_entries[e]);
			end else begin
				static_entry(table_entries[e].value, table_entries[e].text,
					int'(table_entries[e].frames));
			end
		end
		repeat (random_count) begin
			seed         = xorshift(seed);
			random_value = seed[binary_width-1:0];
			static_entry(random_value, decimal_text(int'(random_value)), static_frames);
		end
		$display("%0d errors in %0d checks", errors, checks);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	// budget: every entry's frames plus slack, doubled
	initial begin : watchdog
		int budget_frames;
		budget_frames = 4 + random_count * (static_frames + 4);
		foreach (table_entries[i]) begin
			budget_frames += int'(table_entries[i].frames) + 4;
		end
		#(budget_frames * frame_clocks * clock_period * 2);
		$display("Timeout: the display stopped producing frames before the tests ended");
		$display("Something failed");
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+include
design/display_pkg.sv
design/tick_counter.sv
design/bin_to_bcd.sv
design/digit_scanner.sv
design/counter_display_top.sv
verification/clock_gen.sv
verification/counter_display_tb.sv
